// File: hw/rv32Pkg.sv
package rv32Pkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    localparam wordT RESET_PC    = 32'h0000_0000;
    localparam wordT INSTR_BYTES = 32'd4;  // Every instruction is one word.

    // Major opcodes of the RV32I subset that the core executes.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OPIMM  = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB  // Forwards operand B, used for LUI.
    } aluOpT;

    // Values follow funct3 of the branch instructions.
    typedef enum logic [2:0] {
        COND_EQ  = 3'b000,
        COND_NE  = 3'b001,
        COND_LT  = 3'b100,
        COND_GE  = 3'b101,
        COND_LTU = 3'b110,
        COND_GEU = 3'b111
    } branchCondT;

    typedef enum logic [2:0] {
        ST_HALT = 3'b000,
        ST_IF   = 3'b001,
        ST_ID   = 3'b010,
        ST_EX   = 3'b011,
        ST_MM   = 3'b100,
        ST_WB   = 3'b101
    } coreStateT;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } memOpT;

    typedef struct packed {
        memOpT op;
        wordT  addr;
        wordT  wdata;
    } memReqT;

    typedef struct packed {
        regIdxT     rs1;
        regIdxT     rs2;
        regIdxT     rd;
        wordT       imm;
        aluOpT      aluOp;
        branchCondT cond;
        logic       useImm;
        logic       writesRd;
        logic       isBranch;
        logic       isJal;
        logic       isJalr;
        logic       isLoad;
        logic       isStore;
        logic       isAuipc;
    } decodedT;

endpackage

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  rv32Pkg::wordT    instr,
    output rv32Pkg::decodedT dec
);

    rv32Pkg::wordT immI;
    rv32Pkg::wordT immS;
    rv32Pkg::wordT immB;
    rv32Pkg::wordT immU;
    rv32Pkg::wordT immJ;

    // Bit 30 only selects SUB for register operations; ADDI uses it as an immediate bit.
    function automatic rv32Pkg::aluOpT aluFromFunct(input logic [2:0] funct3,
                                                    input logic bit30,
                                                    input logic isReg);
        case (funct3)
            3'b000:  return (isReg && bit30) ? rv32Pkg::ALU_SUB : rv32Pkg::ALU_ADD;
            3'b001:  return rv32Pkg::ALU_SLL;
            3'b010:  return rv32Pkg::ALU_SLT;
            3'b011:  return rv32Pkg::ALU_SLTU;
            3'b100:  return rv32Pkg::ALU_XOR;
            3'b101:  return bit30 ? rv32Pkg::ALU_SRA : rv32Pkg::ALU_SRL;
            3'b110:  return rv32Pkg::ALU_OR;
            default: return rv32Pkg::ALU_AND;
        endcase
    endfunction

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec       = '0;
        dec.rs1   = instr[19:15];
        dec.rs2   = instr[24:20];
        dec.rd    = instr[11:7];
        dec.cond  = rv32Pkg::branchCondT'(instr[14:12]);
        dec.aluOp = rv32Pkg::ALU_ADD;  // Address and link arithmetic all add.
        case (instr[6:0])
            rv32Pkg::OPC_OP: begin
                dec.aluOp    = aluFromFunct(instr[14:12], instr[30], 1'b1);
                dec.writesRd = 1'b1;
            end
            rv32Pkg::OPC_OPIMM: begin
                dec.aluOp    = aluFromFunct(instr[14:12], instr[30], 1'b0);
                dec.imm      = immI;
                dec.useImm   = 1'b1;
                dec.writesRd = 1'b1;
            end
            rv32Pkg::OPC_LUI: begin
                dec.aluOp    = rv32Pkg::ALU_PASSB;
                dec.imm      = immU;
                dec.useImm   = 1'b1;
                dec.writesRd = 1'b1;
            end
            rv32Pkg::OPC_AUIPC: begin
                dec.imm      = immU;
                dec.useImm   = 1'b1;
                dec.writesRd = 1'b1;
                dec.isAuipc  = 1'b1;
            end
            rv32Pkg::OPC_JAL: begin
                dec.imm      = immJ;
                dec.writesRd = 1'b1;
                dec.isJal    = 1'b1;
            end
            rv32Pkg::OPC_JALR: begin
                dec.imm      = immI;
                dec.useImm   = 1'b1;
                dec.writesRd = 1'b1;
                dec.isJalr   = 1'b1;
            end
            rv32Pkg::OPC_BRANCH: begin
                dec.imm      = immB;
                dec.isBranch = 1'b1;
            end
            rv32Pkg::OPC_LOAD: begin
                dec.imm      = immI;
                dec.useImm   = 1'b1;
                dec.writesRd = 1'b1;
                dec.isLoad   = 1'b1;
            end
            rv32Pkg::OPC_STORE: begin
                dec.imm     = immS;
                dec.useImm  = 1'b1;
                dec.isStore = 1'b1;
            end
            default: ;  // Unknown opcodes fall through as a no-op.
        endcase
    end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  logic            writeEn,
    input  rv32Pkg::regIdxT writeIdx,
    input  rv32Pkg::wordT   writeData,
    input  rv32Pkg::regIdxT readIdxA,
    input  rv32Pkg::regIdxT readIdxB,
    output rv32Pkg::wordT   readDataA,
    output rv32Pkg::wordT   readDataB
);

    rv32Pkg::wordT regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeIdx != '0) begin
            regs[writeIdx] <= writeData;  // Entry zero is never written.
        end
    end

    assign readDataA = regs[readIdxA];
    assign readDataB = regs[readIdxB];

    // x0 keeps its reset value through every write that follows.
    x0ReadsZero: assert property (
        @(posedge clk) disable iff (rst)
        readIdxA == '0 |-> readDataA == '0
    ) else $error("x0 read back a nonzero value.");

endmodule

// File: hw/rv32Alu.sv
`timescale 1ns/1ps

module rv32Alu (
    input  rv32Pkg::aluOpT      aluOp,
    input  rv32Pkg::branchCondT cond,
    input  rv32Pkg::wordT       opA,
    input  rv32Pkg::wordT       opB,
    output rv32Pkg::wordT       result,
    output logic                condTrue
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = opB[4:0];
    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    always_comb begin
        case (aluOp)
            rv32Pkg::ALU_ADD:   result = opA + opB;
            rv32Pkg::ALU_SUB:   result = opA - opB;
            rv32Pkg::ALU_SLL:   result = opA << shamt;
            rv32Pkg::ALU_SLT:   result = {31'b0, lessSigned};
            rv32Pkg::ALU_SLTU:  result = {31'b0, lessUnsigned};
            rv32Pkg::ALU_XOR:   result = opA ^ opB;
            rv32Pkg::ALU_SRL:   result = opA >> shamt;
            rv32Pkg::ALU_SRA:   result = $signed(opA) >>> shamt;
            rv32Pkg::ALU_OR:    result = opA | opB;
            rv32Pkg::ALU_AND:   result = opA & opB;
            rv32Pkg::ALU_PASSB: result = opB;
            default:            result = '0;
        endcase
    end

    // The comparison runs beside the main operation.
    always_comb begin
        case (cond)
            rv32Pkg::COND_EQ:  condTrue = opA == opB;
            rv32Pkg::COND_NE:  condTrue = opA != opB;
            rv32Pkg::COND_LT:  condTrue = lessSigned;
            rv32Pkg::COND_GE:  condTrue = !lessSigned;
            rv32Pkg::COND_LTU: condTrue = lessUnsigned;
            rv32Pkg::COND_GEU: condTrue = !lessUnsigned;
            default:           condTrue = 1'b0;
        endcase
    end

endmodule

// File: hw/progCounter.sv
`timescale 1ns/1ps

module progCounter (
    input  logic          clk,
    input  logic          rst,
    input  logic          step,
    input  logic          redirect,
    input  rv32Pkg::wordT target,
    output rv32Pkg::wordT pc
);

    rv32Pkg::wordT pcReg;
    rv32Pkg::wordT pcNext;

    always_comb begin
        if (redirect) begin
            pcNext = target;
        end else begin
            pcNext = pcReg + rv32Pkg::INSTR_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= rv32Pkg::RESET_PC;
        end else if (step) begin
            pcReg <= pcNext;  // One update per retired instruction.
        end
    end

    assign pc = pcReg;

endmodule

// File: hw/multiCycleCore.sv
`timescale 1ns/1ps

module multiCycleCore (
    input  logic            clk,
    input  logic            rst,
    input  rv32Pkg::wordT   instr,
    input  rv32Pkg::wordT   loadData,
    output rv32Pkg::wordT   instrAddr,
    output rv32Pkg::memReqT memReq
);

    rv32Pkg::coreStateT state;
    logic               redirectReg;

    rv32Pkg::wordT instrReg;
    rv32Pkg::wordT rs1Val;
    rv32Pkg::wordT rs2Val;
    rv32Pkg::wordT immReg;
    rv32Pkg::wordT resultReg;
    rv32Pkg::wordT linkReg;
    rv32Pkg::wordT targetReg;
    rv32Pkg::wordT loadReg;

    rv32Pkg::decodedT dec;
    rv32Pkg::wordT    pc;
    rv32Pkg::wordT    readDataA;
    rv32Pkg::wordT    readDataB;
    rv32Pkg::wordT    aluA;
    rv32Pkg::wordT    aluB;
    rv32Pkg::wordT    aluResult;
    logic             condTrue;
    logic             regWriteEn;
    rv32Pkg::wordT    regWriteData;
    logic             pcStep;

    instrDecoder i_decoder (
        .instr(instrReg),
        .dec  (dec)
    );

    regFile i_regFile (
        .clk      (clk),
        .rst      (rst),
        .writeEn  (regWriteEn),
        .writeIdx (dec.rd),
        .writeData(regWriteData),
        .readIdxA (dec.rs1),
        .readIdxB (dec.rs2),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    rv32Alu i_alu (
        .aluOp   (dec.aluOp),
        .cond    (dec.cond),
        .opA     (aluA),
        .opB     (aluB),
        .result  (aluResult),
        .condTrue(condTrue)
    );

    progCounter i_pc (
        .clk     (clk),
        .rst     (rst),
        .step    (pcStep),
        .redirect(redirectReg),
        .target  (targetReg),
        .pc      (pc)
    );

    assign aluA      = dec.isAuipc ? pc : rs1Val;
    assign aluB      = dec.useImm ? immReg : rs2Val;
    assign instrAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= rv32Pkg::ST_HALT;
            redirectReg <= 1'b0;
        end else begin
            case (state)
                rv32Pkg::ST_HALT: state <= rv32Pkg::ST_IF;
                rv32Pkg::ST_IF:   state <= rv32Pkg::ST_ID;
                rv32Pkg::ST_ID:   state <= rv32Pkg::ST_EX;
                rv32Pkg::ST_EX:   state <= rv32Pkg::ST_MM;
                rv32Pkg::ST_MM:   state <= rv32Pkg::ST_WB;
                default:          state <= rv32Pkg::ST_IF;
            endcase
            if (state == rv32Pkg::ST_EX) begin
                redirectReg <= dec.isJal || dec.isJalr || (dec.isBranch && condTrue);
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            rv32Pkg::ST_IF: instrReg <= instr;
            rv32Pkg::ST_ID: begin
                rs1Val <= readDataA;
                rs2Val <= readDataB;
                immReg <= dec.imm;
            end
            rv32Pkg::ST_EX: begin
                resultReg <= aluResult;
                linkReg   <= pc + rv32Pkg::INSTR_BYTES;
                // JALR drops bit zero of its sum; the rest are PC relative.
                targetReg <= dec.isJalr ? {aluResult[31:1], 1'b0} : pc + immReg;
            end
            rv32Pkg::ST_MM: loadReg <= loadData;
            default: ;
        endcase
    end

    always_comb begin
        memReq.op    = rv32Pkg::MEM_NONE;
        memReq.addr  = resultReg;
        memReq.wdata = rs2Val;
        if (state == rv32Pkg::ST_MM) begin
            if (dec.isLoad) begin
                memReq.op = rv32Pkg::MEM_LOAD;
            end else if (dec.isStore) begin
                memReq.op = rv32Pkg::MEM_STORE;
            end
        end
    end

    assign pcStep     = state == rv32Pkg::ST_WB;
    assign regWriteEn = pcStep && dec.writesRd;

    always_comb begin
        if (dec.isLoad) begin
            regWriteData = loadReg;
        end else if (dec.isJal || dec.isJalr) begin
            regWriteData = linkReg;  // Jumps write the return address.
        end else begin
            regWriteData = resultReg;
        end
    end

    // Data accesses are whole words issued from the MM state.
    memOnlyInMm: assert property (
        @(posedge clk) disable iff (rst)
        memReq.op != rv32Pkg::MEM_NONE |->
            state == rv32Pkg::ST_MM && memReq.addr[1:0] == 2'b00
    ) else $error("Memory request outside the MM state or not word aligned.");

    pcAligned: assert property (
        @(posedge clk) disable iff (rst)
        instrAddr[1:0] == 2'b00
    ) else $error("PC is not word aligned.");

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: sim/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

rv32Pkg::wordT modelRegs [32];
rv32Pkg::wordT modelPc;
rv32Pkg::wordT modelMem [256];

function automatic rv32Pkg::wordT aluRef(input logic [2:0] f3, input logic alt,
                                         input rv32Pkg::wordT a, input rv32Pkg::wordT b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? rv32Pkg::wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchRef(input logic [2:0] f3, input rv32Pkg::wordT a,
                                   input rv32Pkg::wordT b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

// Retires one instruction and returns the data request it should make.
function automatic void modelExec(input rv32Pkg::wordT ins, output rv32Pkg::memReqT req);
    rv32Pkg::wordT a;
    rv32Pkg::wordT b;
    rv32Pkg::wordT immI;
    rv32Pkg::wordT immS;
    rv32Pkg::wordT immB;
    rv32Pkg::wordT immJ;
    rv32Pkg::wordT res;
    rv32Pkg::wordT nextPc;
    logic          wr;
    a       = modelRegs[ins[19:15]];
    b       = modelRegs[ins[24:20]];
    immI    = {{20{ins[31]}}, ins[31:20]};
    immS    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immB    = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    immJ    = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    req     = '0;
    res     = '0;
    wr      = 1'b1;
    nextPc  = modelPc + 32'd4;
    case (ins[6:0])
        rv32Pkg::OPC_OP:    res = aluRef(ins[14:12], ins[30], a, b);
        rv32Pkg::OPC_OPIMM: res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
        rv32Pkg::OPC_LUI:   res = {ins[31:12], 12'b0};
        rv32Pkg::OPC_AUIPC: res = modelPc + {ins[31:12], 12'b0};
        rv32Pkg::OPC_JAL: begin
            res    = modelPc + 32'd4;
            nextPc = modelPc + immJ;
        end
        rv32Pkg::OPC_JALR: begin
            res    = modelPc + 32'd4;
            nextPc = (a + immI) & ~32'd1;
        end
        rv32Pkg::OPC_BRANCH: begin
            wr = 1'b0;
            if (branchRef(ins[14:12], a, b)) nextPc = modelPc + immB;
        end
        rv32Pkg::OPC_LOAD: begin
            req.op   = rv32Pkg::MEM_LOAD;
            req.addr = a + immI;
            res      = modelMem[dataIdx(req.addr)];
        end
        rv32Pkg::OPC_STORE: begin
            wr        = 1'b0;
            req.op    = rv32Pkg::MEM_STORE;
            req.addr  = a + immS;
            req.wdata = b;
            modelMem[dataIdx(req.addr)] = b;
        end
        default: wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) modelRegs[ins[11:7]] = res;
    modelPc = nextPc;
endfunction

`endif

// File: sim/coreTb.sv
`timescale 1ns/1ps

module coreTb;

    localparam int            PROG_LEN  = 200;
    localparam int            SEED      = 85809;
    localparam rv32Pkg::wordT DATA_BASE = 32'h0000_0400;
    localparam int            TIMEOUT_CYCLES = 16 + 5 * (PROG_LEN + 8) + 50;
    localparam rv32Pkg::wordT LAST_ADDR = rv32Pkg::wordT'((PROG_LEN - 1) * 4);

    logic            clk;
    logic            rst;
    rv32Pkg::wordT   instr;
    rv32Pkg::wordT   loadData;
    rv32Pkg::wordT   instrAddr;
    rv32Pkg::memReqT memReq;
    rv32Pkg::wordT   instrMem [256];
    rv32Pkg::wordT   dataMem [256];
    int              cycleCount = 0;

    function automatic logic [7:0] dataIdx(input rv32Pkg::wordT addr);
        rv32Pkg::wordT rel;
        rel = addr - DATA_BASE;
        return rel[9:2];
    endfunction

    `include "isaModel.svh"

    tbClock i_clock (.clk(clk), .rst(rst));

    multiCycleCore i_dut (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .loadData (loadData),
        .instrAddr(instrAddr),
        .memReq   (memReq)
    );

    assign instr    = instrMem[instrAddr[9:2]];
    assign loadData = dataMem[dataIdx(memReq.addr)];  // Answered in the same cycle.

    function automatic rv32Pkg::wordT dataInit(input int i);
        rv32Pkg::wordT addr;
        addr = DATA_BASE + rv32Pkg::wordT'(i * 4);
        return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic rv32Pkg::regIdxT randReg(input int maxIdx);
        return rv32Pkg::regIdxT'($urandom_range(0, maxIdx));
    endfunction

    function automatic logic [11:0] dataOffset();
        return 12'(DATA_BASE) + {2'b00, 8'($urandom()), 2'b00};
    endfunction

    function automatic rv32Pkg::wordT encR(input logic [6:0] f7, input rv32Pkg::regIdxT rs2,
                                           input rv32Pkg::regIdxT rs1, input logic [2:0] f3,
                                           input rv32Pkg::regIdxT rd);
        return {f7, rs2, rs1, f3, rd, rv32Pkg::OPC_OP};
    endfunction

    function automatic rv32Pkg::wordT encI(input logic [11:0] imm, input rv32Pkg::regIdxT rs1,
                                           input logic [2:0] f3, input rv32Pkg::regIdxT rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv32Pkg::wordT encS(input logic [11:0] imm, input rv32Pkg::regIdxT rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv32Pkg::OPC_STORE};
    endfunction

    function automatic rv32Pkg::wordT encB(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], randReg(31), randReg(31), f3, imm[4:1], imm[11],
                rv32Pkg::OPC_BRANCH};
    endfunction

    function automatic rv32Pkg::wordT encJ(input logic [20:0] imm, input rv32Pkg::regIdxT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32Pkg::OPC_JAL};
    endfunction

    // Control transfers only jump forward, and never onto a JALR whose base was skipped.
    task automatic buildProgram();
        int          idx;
        int          kind;
        int          off;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        bit          landed [PROG_LEN];
        for (int i = 0; i < 256; i++) instrMem[i] = '0;
        idx = 0;
        while (idx < PROG_LEN - 1) begin
            kind = int'($urandom_range(0, 9));
            f3   = 3'($urandom());
            alt  = 1'($urandom());
            imm  = 12'($urandom());
            off  = 4 * int'($urandom_range(1, 4));
            if (idx + off / 4 > PROG_LEN - 1) off = 4;
            if (idx % 8 == 7) kind = 10;
            if (kind == 9 && (landed[idx + 1] || idx % 8 == 6 ||
                              idx + 1 + off / 4 > PROG_LEN - 1)) begin
                kind = 3;
            end
            case (kind)
                0, 1, 2: instrMem[idx] = encR({1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0},
                                              randReg(31), randReg(31), f3, randReg(30));
                3, 4: begin
                    if (f3 == 3'b001) imm[11:5] = '0;
                    if (f3 == 3'b101) imm[11:5] = {1'b0, alt, 5'b0};
                    instrMem[idx] = encI(imm, randReg(31), f3, randReg(30), rv32Pkg::OPC_OPIMM);
                end
                5: instrMem[idx] = {20'($urandom()), randReg(30),
                                    alt ? rv32Pkg::OPC_LUI : rv32Pkg::OPC_AUIPC};
                6: instrMem[idx] = encI(dataOffset(), 5'd0, 3'b010, randReg(30),
                                        rv32Pkg::OPC_LOAD);
                7: begin
                    if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // Funct3 2 and 3 are not branches.
                    instrMem[idx] = encB(13'(off), f3);
                    landed[idx + off / 4] = 1'b1;
                end
                8: begin
                    instrMem[idx] = encJ(21'(off), randReg(30));
                    landed[idx + off / 4] = 1'b1;
                end
                9: begin
                    // The base gets bit zero set so that JALR has to clear it.
                    instrMem[idx] = encI(12'((idx + 1) * 4 + off + 1), 5'd0, 3'b000, 5'd31,
                                         rv32Pkg::OPC_OPIMM);
                    instrMem[idx + 1] = encI(12'd0, 5'd31, 3'b000, randReg(30),
                                             rv32Pkg::OPC_JALR);
                    landed[idx + 1 + off / 4] = 1'b1;
                    idx++;
                end
                default: instrMem[idx] = encS(dataOffset(), randReg(31));
            endcase
            idx++;
        end
        instrMem[PROG_LEN - 1] = encJ(21'd0, 5'd0);
    endtask

    task automatic reportFailure(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "Stopping at the first error.");
    endtask

    task automatic checkAddr(input rv32Pkg::wordT got, input rv32Pkg::wordT exp,
                             input string what);
        if (got !== exp) reportFailure($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic checkWord(input rv32Pkg::wordT got, input rv32Pkg::wordT exp,
                             input string what);
        if (got !== exp) reportFailure($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic checkReq(input rv32Pkg::memReqT got, input rv32Pkg::memReqT exp,
                            input string what);
        if (got.op !== exp.op || (exp.op != rv32Pkg::MEM_NONE && got.addr !== exp.addr)) begin
            reportFailure($sformatf("%s request op %0d addr %h, expected %0d %h",
                                    what, got.op, got.addr, exp.op, exp.addr));
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the program never reached its final loop.");
            $display("Test failures found");
            $fatal(1, "Timeout after %0d cycles.", cycleCount);
        end
    end

    initial begin
        rv32Pkg::wordT   ins;
        rv32Pkg::memReqT expReq;
        rv32Pkg::memReqT idleReq;
        void'($urandom(SEED));
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            dataMem[i]  = dataInit(i);
            modelMem[i] = dataInit(i);
        end
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        modelPc = rv32Pkg::RESET_PC;
        idleReq = '0;
        @(negedge clk);
        checkReq(memReq, idleReq, "Reset");
        checkAddr(instrAddr, rv32Pkg::RESET_PC, "Reset PC");
        do @(posedge clk); while (rst);  // This edge leaves the HALT state.
        forever begin
            @(negedge clk);
            checkAddr(instrAddr, modelPc, "Fetch address");
            checkReq(memReq, idleReq, "Fetch cycle");
            if (instrAddr == LAST_ADDR) break;
            ins = instrMem[instrAddr[9:2]];
            modelExec(ins, expReq);
            for (int c = 2; c <= 5; c++) begin
                @(negedge clk);
                checkReq(memReq, (c == 4) ? expReq : idleReq, $sformatf("Cycle %0d", c));
                if (c == 4 && expReq.op == rv32Pkg::MEM_STORE) begin
                    checkWord(memReq.wdata, expReq.wdata, "Store data");
                end
                if (c == 4) begin
                    @(posedge clk);
                    if (expReq.op == rv32Pkg::MEM_STORE) begin
                        dataMem[dataIdx(expReq.addr)] <= expReq.wdata;
                    end
                end
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: compile.f
+incdir+sim
hw/rv32Pkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/rv32Alu.sv
hw/progCounter.sv
hw/multiCycleCore.sv
sim/tbClock.sv
sim/coreTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module coreTb -f compile.f -o simCore

# The simulator exits nonzero on a failure; the log decides the result.
./obj_dir/simCore > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed!" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi
